// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [5:0] opcode_t;   // Primary opcode, instr[31:26]
    typedef logic [5:0] funct_t;    // R-type function, instr[5:0]
    typedef logic [4:0] rt_field_t; // rt field, instr[20:16]

    // Primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;

    // SPECIAL function codes
    localparam funct_t FN_SLL   = 6'b000000;
    localparam funct_t FN_SRL   = 6'b000010;
    localparam funct_t FN_SRA   = 6'b000011;
    localparam funct_t FN_SLLV  = 6'b000100;
    localparam funct_t FN_SRLV  = 6'b000110;
    localparam funct_t FN_SRAV  = 6'b000111;
    localparam funct_t FN_JR    = 6'b001000;
    localparam funct_t FN_JALR  = 6'b001001;
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MULT  = 6'b011000;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_DIV   = 6'b011010;
    localparam funct_t FN_DIVU  = 6'b011011;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUBU  = 6'b100011;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;
    localparam funct_t FN_SLT   = 6'b101010;
    localparam funct_t FN_SLTU  = 6'b101011;

    // REGIMM branch selects in rt
    localparam rt_field_t RT_BLTZ   = 5'b00000;
    localparam rt_field_t RT_BGEZ   = 5'b00001;
    localparam rt_field_t RT_BLTZAL = 5'b10000;
    localparam rt_field_t RT_BGEZAL = 5'b10001;

endpackage

`default_nettype wire

// File: common/alu_pkg.sv
`default_nettype none

package alu_pkg;

    typedef logic [31:0] word_t;  // Register-width operand
    typedef logic [4:0]  shamt_t; // Shift amount

    // Encoding kept compatible with the older single-module ALU
    typedef enum logic [4:0] {
        ALU_AND     = 5'b00000,
        ALU_OR      = 5'b00001,
        ALU_XOR     = 5'b00010,
        ALU_ADDU    = 5'b00011,
        ALU_SUBU    = 5'b00100,
        ALU_SLTU    = 5'b00101,
        ALU_SLT     = 5'b00110,
        ALU_MULTU   = 5'b00111,
        ALU_MULT    = 5'b01000,
        ALU_SLL     = 5'b01001,
        ALU_SLLV    = 5'b01010,
        ALU_SRA     = 5'b01011,
        ALU_SRL     = 5'b01100,
        ALU_SRAV    = 5'b01101,
        ALU_SRLV    = 5'b01110,
        ALU_DIV     = 5'b01111,
        ALU_DIVU    = 5'b10000,
        ALU_MFHI    = 5'b10001,
        ALU_MFLO    = 5'b10010,
        ALU_BLTZ    = 5'b10011,
        ALU_BGTZ    = 5'b10100,
        ALU_BGEZ    = 5'b10101,
        ALU_BNE     = 5'b10110,
        ALU_BLEZ    = 5'b10111,
        ALU_JR      = 5'b11000,
        ALU_ILLEGAL = 5'b11111
    } alu_op_t;

    typedef enum logic [1:0] {
        SHIFT_LL = 2'b00, // Left logical
        SHIFT_RL = 2'b01, // Right logical
        SHIFT_RA = 2'b10  // Right arithmetic
    } shift_kind_t;

    typedef struct packed {
        logic               valid;    // Qualifies the HI/LO write
        isa_pkg::opcode_t   opcode;
        isa_pkg::funct_t    funct;
        isa_pkg::rt_field_t rt_field;
        shamt_t             shamt;
        word_t              a;        // rs value
        word_t              b;        // rt value or extended immediate
    } ex_in_t;

    typedef struct packed {
        word_t result;
        logic  zero;
        logic  illegal;
    } ex_out_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

`default_nettype wire

// File: design/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
    input  isa_pkg::opcode_t   opcode,
    input  isa_pkg::funct_t    funct,
    input  isa_pkg::rt_field_t rt_field,
    output alu_pkg::alu_op_t   alu_op
);

    alu_pkg::alu_op_t special_op;
    alu_pkg::alu_op_t regimm_op;

    // R-type ops selected by funct
    always_comb begin
        case (funct)
            isa_pkg::FN_SLL:   special_op = alu_pkg::ALU_SLL;
            isa_pkg::FN_SRL:   special_op = alu_pkg::ALU_SRL;
            isa_pkg::FN_SRA:   special_op = alu_pkg::ALU_SRA;
            isa_pkg::FN_SLLV:  special_op = alu_pkg::ALU_SLLV;
            isa_pkg::FN_SRLV:  special_op = alu_pkg::ALU_SRLV;
            isa_pkg::FN_SRAV:  special_op = alu_pkg::ALU_SRAV;
            isa_pkg::FN_JR:    special_op = alu_pkg::ALU_JR;
            isa_pkg::FN_JALR:  special_op = alu_pkg::ALU_JR;    // Link handled upstream
            isa_pkg::FN_MFHI:  special_op = alu_pkg::ALU_MFHI;
            isa_pkg::FN_MFLO:  special_op = alu_pkg::ALU_MFLO;
            isa_pkg::FN_MULT:  special_op = alu_pkg::ALU_MULT;
            isa_pkg::FN_MULTU: special_op = alu_pkg::ALU_MULTU;
            isa_pkg::FN_DIV:   special_op = alu_pkg::ALU_DIV;
            isa_pkg::FN_DIVU:  special_op = alu_pkg::ALU_DIVU;
            isa_pkg::FN_ADDU:  special_op = alu_pkg::ALU_ADDU;
            isa_pkg::FN_SUBU:  special_op = alu_pkg::ALU_SUBU;
            isa_pkg::FN_AND:   special_op = alu_pkg::ALU_AND;
            isa_pkg::FN_OR:    special_op = alu_pkg::ALU_OR;
            isa_pkg::FN_XOR:   special_op = alu_pkg::ALU_XOR;
            isa_pkg::FN_SLT:   special_op = alu_pkg::ALU_SLT;
            isa_pkg::FN_SLTU:  special_op = alu_pkg::ALU_SLTU;
            default:           special_op = alu_pkg::ALU_ILLEGAL; // ADD, SUB, MTHI...
        endcase
    end

    // REGIMM branches selected by rt, link forms share the condition
    always_comb begin
        case (rt_field)
            isa_pkg::RT_BLTZ,
            isa_pkg::RT_BLTZAL: regimm_op = alu_pkg::ALU_BLTZ;
            isa_pkg::RT_BGEZ,
            isa_pkg::RT_BGEZAL: regimm_op = alu_pkg::ALU_BGEZ;
            default:            regimm_op = alu_pkg::ALU_ILLEGAL;
        endcase
    end

    always_comb begin
        case (opcode)
            isa_pkg::OP_SPECIAL: alu_op = special_op;
            isa_pkg::OP_REGIMM:  alu_op = regimm_op;
            isa_pkg::OP_BEQ:     alu_op = alu_pkg::ALU_SUBU; // Zero flags equality
            isa_pkg::OP_BNE:     alu_op = alu_pkg::ALU_BNE;
            isa_pkg::OP_BLEZ:    alu_op = alu_pkg::ALU_BLEZ;
            isa_pkg::OP_BGTZ:    alu_op = alu_pkg::ALU_BGTZ;
            isa_pkg::OP_ADDIU:   alu_op = alu_pkg::ALU_ADDU;
            isa_pkg::OP_SLTI:    alu_op = alu_pkg::ALU_SLT;
            isa_pkg::OP_SLTIU:   alu_op = alu_pkg::ALU_SLTU;
            isa_pkg::OP_ANDI:    alu_op = alu_pkg::ALU_AND;
            isa_pkg::OP_ORI:     alu_op = alu_pkg::ALU_OR;
            isa_pkg::OP_XORI:    alu_op = alu_pkg::ALU_XOR;
            default:             alu_op = alu_pkg::ALU_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// File: alu/shifter.sv
`timescale 1ns/1ps
`default_nettype none

module shifter (
    input  alu_pkg::word_t       value,
    input  alu_pkg::shift_kind_t shift_kind,
    input  alu_pkg::shamt_t      shift_amount,
    output alu_pkg::word_t       shifted
);

    alu_pkg::word_t stage [0:5];
    alu_pkg::word_t value_rev;
    alu_pkg::word_t stage_rev;
    logic           left;
    logic           fill;

    assign left = (shift_kind == alu_pkg::SHIFT_LL);
    assign fill = (shift_kind == alu_pkg::SHIFT_RA) && value[31]; // Sign fill for SRA

    // Left shifts run through the right-shift network on reversed bits
    for (genvar i = 0; i < 32; i++) begin : g_rev
        assign value_rev[i] = value[31 - i];
        assign stage_rev[i] = stage[5][31 - i];
    end

    assign stage[0] = left ? value_rev : value;

    // One stage per amount bit, shifting by 1, 2, 4, 8, 16
    for (genvar i = 0; i < 5; i++) begin : g_stage
        localparam int STEP = 1 << i;

        assign stage[i + 1] = shift_amount[i] ?
                              {{STEP{fill}}, stage[i][31:STEP]} : stage[i];
    end

    assign shifted = left ? stage_rev : stage[5];

endmodule

`default_nettype wire

// File: alu/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  alu_pkg::alu_op_t     alu_op,
    input  alu_pkg::word_t       a,
    input  alu_pkg::word_t       b,
    input  alu_pkg::shamt_t      shamt,
    input  alu_pkg::hilo_t       hilo,
    output alu_pkg::shift_kind_t shift_kind,
    output alu_pkg::shamt_t      shift_amount,
    input  alu_pkg::word_t       shifted,
    output alu_pkg::ex_out_t     ex_out
);

    alu_pkg::word_t result;
    logic           a_neg;
    logic           a_is_zero;

    assign a_neg     = a[31];
    assign a_is_zero = (a == '0);

    // Shift control for the barrel shifter
    always_comb begin
        case (alu_op)
            alu_pkg::ALU_SRL,
            alu_pkg::ALU_SRLV: shift_kind = alu_pkg::SHIFT_RL;
            alu_pkg::ALU_SRA,
            alu_pkg::ALU_SRAV: shift_kind = alu_pkg::SHIFT_RA;
            default:           shift_kind = alu_pkg::SHIFT_LL;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_pkg::ALU_SLLV,
            alu_pkg::ALU_SRLV,
            alu_pkg::ALU_SRAV: shift_amount = a[4:0]; // Low bits of rs
            default:           shift_amount = shamt;
        endcase
    end

    // Branch ops return 0 when taken, so zero reads as taken
    always_comb begin
        case (alu_op)
            alu_pkg::ALU_AND:  result = a & b;
            alu_pkg::ALU_OR:   result = a | b;
            alu_pkg::ALU_XOR:  result = a ^ b;
            alu_pkg::ALU_ADDU: result = a + b;
            alu_pkg::ALU_SUBU: result = a - b;
            alu_pkg::ALU_SLTU: result = {31'b0, a < b};
            alu_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            alu_pkg::ALU_SLL,
            alu_pkg::ALU_SLLV,
            alu_pkg::ALU_SRL,
            alu_pkg::ALU_SRLV,
            alu_pkg::ALU_SRA,
            alu_pkg::ALU_SRAV: result = shifted;
            alu_pkg::ALU_MFHI: result = hilo.hi;
            alu_pkg::ALU_MFLO: result = hilo.lo;
            alu_pkg::ALU_BLTZ: result = {31'b0, !a_neg};
            alu_pkg::ALU_BGEZ: result = {31'b0, a_neg};
            alu_pkg::ALU_BGTZ: result = {31'b0, a_neg || a_is_zero};
            alu_pkg::ALU_BLEZ: result = {31'b0, !(a_neg || a_is_zero)};
            alu_pkg::ALU_BNE:  result = {31'b0, a == b};
            alu_pkg::ALU_JR:   result = a;                // Jump target
            default:           result = '0;               // Mult, div and illegal
        endcase
    end

    assign ex_out = '{
        result:  result,
        zero:    (result == '0),
        illegal: (alu_op == alu_pkg::ALU_ILLEGAL)
    };

endmodule

`default_nettype wire

// File: alu/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid,
    input  alu_pkg::alu_op_t alu_op,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    output alu_pkg::hilo_t   hilo
);

    logic           is_mul;
    logic           is_div;
    logic           is_signed;
    logic           neg_a;
    logic           neg_b;
    logic           div_zero;
    logic           hilo_we;
    alu_pkg::word_t mag_a;
    alu_pkg::word_t mag_b;
    alu_pkg::word_t divisor;
    alu_pkg::word_t quot_mag;
    alu_pkg::word_t rem_mag;
    logic [63:0]    prod_mag;
    logic [63:0]    product;
    alu_pkg::hilo_t hilo_next;
    alu_pkg::hilo_t hilo_q;

    assign is_mul    = (alu_op == alu_pkg::ALU_MULT) || (alu_op == alu_pkg::ALU_MULTU);
    assign is_div    = (alu_op == alu_pkg::ALU_DIV)  || (alu_op == alu_pkg::ALU_DIVU);
    assign is_signed = (alu_op == alu_pkg::ALU_MULT) || (alu_op == alu_pkg::ALU_DIV);

    // Magnitudes, 0x80000000 stays 2^31 as unsigned
    assign neg_a = is_signed && a[31];
    assign neg_b = is_signed && b[31];
    assign mag_a = neg_a ? -a : a;
    assign mag_b = neg_b ? -b : b;

    assign prod_mag = {32'b0, mag_a} * {32'b0, mag_b};
    assign product  = (neg_a ^ neg_b) ? -prod_mag : prod_mag;

    // Divisor forced to 1 on zero so the unused quotient stays defined
    assign div_zero = (b == '0);
    assign divisor  = div_zero ? 32'd1 : mag_b;
    assign quot_mag = mag_a / divisor;
    assign rem_mag  = mag_a % divisor;

    // Quotient truncates toward zero, remainder follows the dividend
    always_comb begin
        if (is_div) begin
            hilo_next.hi = neg_a ? -rem_mag : rem_mag;
            hilo_next.lo = (neg_a ^ neg_b) ? -quot_mag : quot_mag;
        end else begin
            hilo_next.hi = product[63:32];
            hilo_next.lo = product[31:0];
        end
    end

    assign hilo_we = valid && (is_mul || (is_div && !div_zero));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= hilo_next;
        end
    end

    assign hilo = hilo_q; // Same-cycle mfhi/mflo sees the old value

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  alu_pkg::ex_in_t  ex_in,
    output alu_pkg::ex_out_t ex_out
);

    alu_pkg::alu_op_t     alu_op;
    alu_pkg::hilo_t       hilo;
    alu_pkg::shift_kind_t shift_kind;
    alu_pkg::shamt_t      shift_amount;
    alu_pkg::word_t       shifted;

    alu_decoder alu_decoder_i (
        .opcode   (ex_in.opcode),
        .funct    (ex_in.funct),
        .rt_field (ex_in.rt_field),
        .alu_op   (alu_op)
    );

    alu alu_i (
        .alu_op       (alu_op),
        .a            (ex_in.a),
        .b            (ex_in.b),
        .shamt        (ex_in.shamt),
        .hilo         (hilo),
        .shift_kind   (shift_kind),
        .shift_amount (shift_amount),
        .shifted      (shifted),
        .ex_out       (ex_out)
    );

    // Shifted operand is always rt
    shifter shifter_i (
        .value        (ex_in.b),
        .shift_kind   (shift_kind),
        .shift_amount (shift_amount),
        .shifted      (shifted)
    );

    muldiv_unit muldiv_unit_i (
        .clk    (clk),
        .arst_n (arst_n),
        .valid  (ex_in.valid),
        .alu_op (alu_op),
        .a      (ex_in.a),
        .b      (ex_in.b),
        .hilo   (hilo)
    );

endmodule

`default_nettype wire

// File: sim/ex_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_sva (
    input logic             clk,
    input logic             arst_n,
    input logic             valid,
    input alu_pkg::hilo_t   hilo,
    input alu_pkg::ex_out_t ex_out
);

    int fail_count = 0; // Failed assertions so far

    // HI and LO cleared while reset is held
    hilo_reset_a: assert property (@(posedge clk) !arst_n |-> hilo == '0)
        else begin
            $error("HI/LO not zero during reset");
            fail_count++;
        end

    // No write without valid
    hilo_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        !valid |=> $stable(hilo))
        else begin
            $error("HI/LO changed while valid was low");
            fail_count++;
        end

    // Unknown encodings return a zero result
    illegal_result_a: assert property (@(posedge clk) disable iff (!arst_n)
        ex_out.illegal |-> (ex_out.result == '0) && ex_out.zero)
        else begin
            $error("illegal op returned a nonzero result");
            fail_count++;
        end

endmodule

bind ex_stage ex_stage_sva ex_stage_sva_i (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (ex_in.valid),
    .hilo   (hilo),
    .ex_out (ex_out)
);

`default_nettype wire

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rt;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        zero;
        logic        ill;
    } vec_t;

    logic             clk;
    logic             arst_n;
    alu_pkg::ex_in_t  ex_in;
    alu_pkg::ex_out_t ex_out;
    vec_t             vecs[$];
    int               errors;
    integer           seed;
    logic [31:0]      exp_hi;
    logic [31:0]      exp_lo;

    ex_stage ex_stage_i (.clk(clk), .arst_n(arst_n), .ex_in(ex_in), .ex_out(ex_out));

    always #2 clk = ~clk;

    task automatic add_vec(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rt,
                           input logic [4:0] sh, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] res, input logic z, input logic il);
        vecs.push_back('{op, fn, rt, sh, a, b, res, z, il});
    endtask

    // Drive on the rising edge, return at the falling edge once settled
    task automatic apply(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rt,
                         input logic [4:0] sh, input logic [31:0] a, input logic [31:0] b,
                         input logic v);
        @(posedge clk);
        ex_in <= '{valid: v, opcode: op, funct: fn, rt_field: rt, shamt: sh, a: a, b: b};
        @(negedge clk);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Reference HI/LO from the ISA arithmetic, div by zero keeps old values
    task automatic muldiv_model(input logic [5:0] fn, input logic [31:0] a, input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      q;
        longint      r;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (fn == isa_pkg::FN_MULT || fn == isa_pkg::FN_MULTU) begin
            p = (fn == isa_pkg::FN_MULT) ? 64'(sa * sb) : {32'b0, a} * {32'b0, b};
            exp_hi = p[63:32];
            exp_lo = p[31:0];
        end else if (b != 0) begin
            q = (fn == isa_pkg::FN_DIV) ? sa / sb : longint'({32'b0, a} / {32'b0, b});
            r = (fn == isa_pkg::FN_DIV) ? sa % sb : longint'({32'b0, a} % {32'b0, b});
            exp_hi = r[31:0];
            exp_lo = q[31:0];
        end
    endtask

    initial begin
        logic [5:0]  fns [4];
        logic [31:0] ra;
        logic [31:0] rb;
        int          wait_cnt;
        clk    = 1'b0;
        arst_n = 1'b0;
        ex_in  = '0;
        errors = 0;
        seed   = 32'h9869;
        exp_hi = '0;
        exp_lo = '0;
        fns    = '{isa_pkg::FN_MULT, isa_pkg::FN_MULTU, isa_pkg::FN_DIV, isa_pkg::FN_DIVU};

        // HI/LO reads first, still holding their reset value
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_MFHI, 0, 0, 32'h1, 32'h2, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_MFLO, 0, 0, 32'h1, 32'h2, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_AND, 0, 0, 32'hF0F0FFFF, 32'h0FF000FF,
                32'h00F000FF, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_OR, 0, 0, 32'hF0000000, 32'hF, 32'hF000000F, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_XOR, 0, 0, 32'hFFFF0000, 32'hFF00FF00,
                32'h00FFFF00, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 0, 0, 32'h7FFFFFFF, 1, 32'h80000000, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_ADDU, 0, 0, 32'hFFFFFFFF, 1, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SUBU, 0, 0, 32'h0, 1, 32'hFFFFFFFF, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLT, 0, 0, 32'h80000000, 32'h7FFFFFFF, 1, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLT, 0, 0, 32'h7FFFFFFF, 32'h80000000, 0, 1, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLTU, 0, 0, 32'h80000000, 32'h7FFFFFFF, 0, 1, 0);
        add_vec(isa_pkg::OP_SLTIU, 0, 0, 0, 32'h1, 32'hFFFFFFFF, 1, 0, 0);
        add_vec(isa_pkg::OP_ADDIU, 0, 0, 0, 32'h10, 32'hFFFFFFFE, 32'hE, 0, 0);
        add_vec(isa_pkg::OP_ANDI, 0, 0, 0, 32'h12345678, 32'hFFFF, 32'h5678, 0, 0);
        // Shifts act on b
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLL, 0, 4, 0, 32'hFF, 32'hFF0, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLL, 0, 31, 0, 32'h3, 32'h80000000, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRL, 0, 0, 0, 32'h80000001, 32'h80000001, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRL, 0, 31, 0, 32'h80000000, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRA, 0, 4, 0, 32'h80000000, 32'hF8000000, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRA, 0, 31, 0, 32'h80000000, 32'hFFFFFFFF, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SLLV, 0, 0, 32'h24, 32'h1, 32'h10, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRLV, 0, 0, 32'hFFFFFFFF, 32'hFFFFFFFF, 1, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRAV, 0, 0, 32'h21, 32'h80000000, 32'hC0000000,
                0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_SRAV, 0, 0, 32'h20, 32'hF0000000, 32'hF0000000,
                0, 0);
        // Branches return 0 when taken
        add_vec(isa_pkg::OP_BEQ, 0, 0, 0, 32'h5, 32'h5, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_BEQ, 0, 0, 0, 32'h5, 32'h6, 32'hFFFFFFFF, 0, 0);
        add_vec(isa_pkg::OP_BNE, 0, 0, 0, 32'h5, 32'h6, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_BNE, 0, 0, 0, 32'h5, 32'h5, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_REGIMM, 0, isa_pkg::RT_BLTZ, 0, 32'hFFFFFFFF, 0, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_REGIMM, 0, isa_pkg::RT_BLTZ, 0, 32'h0, 0, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_REGIMM, 0, isa_pkg::RT_BLTZ, 0, 32'h5, 0, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_REGIMM, 0, isa_pkg::RT_BGEZ, 0, 32'h0, 0, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_REGIMM, 0, isa_pkg::RT_BGEZ, 0, 32'h7FFFFFFF, 0, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_REGIMM, 0, isa_pkg::RT_BGEZAL, 0, 32'hFFFFFFFB, 0, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_BGTZ, 0, 0, 0, 32'h1, 0, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_BGTZ, 0, 0, 0, 32'h0, 0, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_BGTZ, 0, 0, 0, 32'h80000000, 0, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_BLEZ, 0, 0, 0, 32'hFFFFFFFF, 0, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_BLEZ, 0, 0, 0, 32'h0, 0, 32'h0, 1, 0);
        add_vec(isa_pkg::OP_BLEZ, 0, 0, 0, 32'h7, 0, 32'h1, 0, 0);
        add_vec(isa_pkg::OP_SPECIAL, isa_pkg::FN_JR, 0, 0, 32'h00401000, 0, 32'h00401000, 0, 0);
        // ADD traps are not implemented, so funct 100000 is unlisted
        add_vec(isa_pkg::OP_SPECIAL, 6'b100000, 0, 0, 32'h1, 32'h1, 32'h0, 1, 1);
        add_vec(6'b111111, 0, 0, 0, 32'h1, 32'h1, 32'h0, 1, 1);

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        wait_cnt = 0;
        // Release as seen by the HI/LO register inside the DUT
        while (ex_stage_i.muldiv_unit_i.arst_n !== 1'b1 && wait_cnt < 10) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (ex_stage_i.muldiv_unit_i.arst_n !== 1'b1) begin
            $display("Timeout waiting for reset release");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            foreach (vecs[i]) begin
                apply(vecs[i].opcode, vecs[i].funct, vecs[i].rt, vecs[i].shamt,
                      vecs[i].a, vecs[i].b, 1'b1);
                check("result", vecs[i].res, ex_out.result);
                check("zero", {31'b0, vecs[i].zero}, {31'b0, ex_out.zero});
                check("illegal", {31'b0, vecs[i].ill}, {31'b0, ex_out.illegal});
            end

            for (int i = 0; i < 48; i++) begin
                ra = $random(seed);
                rb = $random(seed);
                if (i < 8) begin
                    ra = 32'h80000000; // Most negative value against -1 and itself
                    rb = i[2] ? 32'hFFFFFFFF : 32'h80000000;
                end
                if (i % 16 >= 14) begin
                    rb = 32'h0;
                end
                apply(isa_pkg::OP_SPECIAL, fns[i % 4], 0, 0, ra, rb, 1'b1);
                check("mdu result", 32'h0, ex_out.result);
                muldiv_model(fns[i % 4], ra, rb);
                // Same op without valid must leave HI/LO alone
                apply(isa_pkg::OP_SPECIAL, fns[i % 4], 0, 0, ~ra, rb, 1'b0);
                apply(isa_pkg::OP_SPECIAL, isa_pkg::FN_MFHI, 0, 0, 0, 0, 1'b0);
                check("hi", exp_hi, ex_out.result);
                apply(isa_pkg::OP_SPECIAL, isa_pkg::FN_MFLO, 0, 0, 0, 0, 1'b0);
                check("lo", exp_lo, ex_out.result);
            end

            repeat (2) @(negedge clk);
            $display("Checks done, errors: %0d, assertion failures: %0d", errors,
                     ex_stage_i.ex_stage_sva_i.fail_count);
            if (errors == 0 && ex_stage_i.ex_stage_sva_i.fail_count == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
common/isa_pkg.sv
common/alu_pkg.sv
design/alu_decoder.sv
alu/shifter.sv
alu/alu.sv
alu/muldiv_unit.sv
design/ex_stage.sv
sim/ex_stage_sva.sv
sim/tb_ex_stage.sv

// File: Makefile
TOP = tb_ex_stage

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
